// ==== rtl/i2c_logger_pkg.sv ====
// i2c logger shared types, widths and status byte layout
package i2c_logger_pkg;

    // ------------------------------------------------------------
    // bus observer
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        ST_WAIT  = 2'd0,                            // bus idle
        ST_START = 2'd1,                            // start seen, scl still high
        ST_DATA  = 2'd2,                            // data bits of a byte
        ST_ACK   = 2'd3                             // ninth clock
    } bus_state_t;

    localparam int BYTE_W     = 8;
    localparam int CNT_W      = 4;
    localparam int FILT_DEPTH = 2;                  // past samples per line

    localparam logic [CNT_W-1:0] ACK_BIT = CNT_W'(9);  // count after the ack rise

    // ------------------------------------------------------------
    // records and output stream
    // ------------------------------------------------------------
    typedef logic [BYTE_W-1:0] byte_t;

    typedef struct packed {
        byte_t data;
        logic  ack;                                 // sda low on ninth clock
        logic  first;                               // first byte after start
    } rec_t;

    localparam int STAT_ACK_POS   = 0;
    localparam int STAT_FIRST_POS = 1;

endpackage

// ==== rtl/line_filter.sv ====
// i2c line filter: synchronizes and deglitches scl/sda, flags start, stop and scl edges
`timescale 1ns/1ns

module line_filter (
    input  logic aclk,
    input  logic aresetn,
    input  logic i_scl,
    input  logic i_sda,
    output logic o_scl,
    output logic o_sda,
    output logic o_start,
    output logic o_stop,
    output logic o_scl_rise,
    output logic o_scl_fall
);

    localparam int DEPTH = i2c_logger_pkg::FILT_DEPTH;

    logic [1:0]       pin;                          // [0] scl, [1] sda
    logic [DEPTH-1:0] hist [2];
    logic [1:0]       lvl;                          // filtered levels
    logic [1:0]       lvl_d;
    logic             scl_hi;

    assign pin = {i_sda, i_scl};

    // level flips only once all past samples agree with the pin
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            hist[0] <= '1;
            hist[1] <= '1;
            lvl     <= '1;                          // idle bus is high
            lvl_d   <= '1;
        end else begin
            for (int i = 0; i < 2; i++) begin
                hist[i] <= {hist[i][DEPTH-2:0], pin[i]};
                if (lvl[i]) begin
                    lvl[i] <= (|hist[i]) | pin[i];
                end else begin
                    lvl[i] <= (&hist[i]) & pin[i];
                end
            end
            lvl_d <= lvl;
        end
    end

    assign o_scl = lvl[0];
    assign o_sda = lvl[1];

    // ------------------------------------------------------------
    // events, one clock after the filtered change
    // ------------------------------------------------------------
    assign scl_hi     = lvl[0] & lvl_d[0];
    assign o_start    = scl_hi & ~lvl[1] & lvl_d[1];   // sda falls, scl high
    assign o_stop     = scl_hi & lvl[1] & ~lvl_d[1];   // sda rises, scl high
    assign o_scl_rise = lvl[0] & ~lvl_d[0];
    assign o_scl_fall = ~lvl[0] & lvl_d[0];

    // hysteresis keeps bus conditions apart by more than a clock
    a_start_stop_apart: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_start || o_stop) |-> !(o_start && o_stop) ##1 !(o_start || o_stop));

endmodule

// ==== rtl/bus_fsm.sv ====
// i2c bus state machine tracking frames, with protocol error flag
`timescale 1ns/1ns

module bus_fsm (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                i_start,
    input  logic                                i_stop,
    input  logic                                i_scl_fall,
    input  logic [i2c_logger_pkg::CNT_W-1:0]    i_bit_cnt,
    output i2c_logger_pkg::bus_state_t          o_state,
    output logic                                o_bus_active,
    output logic                                o_bus_err
);

    logic boundary;                                 // between bytes

    assign boundary = (i_bit_cnt == '0) || (i_bit_cnt == 1) ||
                      (i_bit_cnt == i2c_logger_pkg::ACK_BIT);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_state   <= i2c_logger_pkg::ST_WAIT;
            o_bus_err <= 1'b0;
        end else if (i_stop) begin
            o_state <= i2c_logger_pkg::ST_WAIT;
            if ((o_state == i2c_logger_pkg::ST_DATA && !boundary) ||
                o_state == i2c_logger_pkg::ST_START) begin
                o_bus_err <= 1'b1;                  // byte cut short or empty frame
            end
        end else if (i_start) begin
            o_state <= i2c_logger_pkg::ST_START;
            if (o_state == i2c_logger_pkg::ST_DATA && !boundary) begin
                o_bus_err <= 1'b1;
            end else if (o_state == i2c_logger_pkg::ST_WAIT ||
                         o_state == i2c_logger_pkg::ST_DATA) begin
                o_bus_err <= 1'b0;                  // clean (repeated) start
            end
        end else if (i_scl_fall) begin
            case (o_state)
                i2c_logger_pkg::ST_START: o_state <= i2c_logger_pkg::ST_DATA;
                i2c_logger_pkg::ST_DATA: begin
                    if (i_bit_cnt == i2c_logger_pkg::ACK_BIT - 1'b1) begin
                        o_state <= i2c_logger_pkg::ST_ACK;
                    end
                end
                i2c_logger_pkg::ST_ACK:   o_state <= i2c_logger_pkg::ST_DATA;
                default:                  o_state <= i2c_logger_pkg::ST_WAIT;
            endcase
        end
    end

    assign o_bus_active = (o_state != i2c_logger_pkg::ST_WAIT);

endmodule

// ==== rtl/bit_counter.sv ====
// i2c bit counter, counts scl rises within a byte frame
`timescale 1ns/1ns

module bit_counter (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                i_scl_rise,
    input  logic                                i_start,
    input  logic                                i_stop,
    input  i2c_logger_pkg::bus_state_t          i_state,
    output logic [i2c_logger_pkg::CNT_W-1:0]    o_bit_cnt
);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_bit_cnt <= '0;
        end else if (i_start || i_stop) begin
            o_bit_cnt <= '0;
        end else begin
            case (i_state)
                i2c_logger_pkg::ST_DATA, i2c_logger_pkg::ST_ACK: begin
                    if (i_scl_rise) begin
                        if (o_bit_cnt == i2c_logger_pkg::ACK_BIT) begin
                            o_bit_cnt <= i2c_logger_pkg::CNT_W'(1);  // next frame, no gap
                        end else begin
                            o_bit_cnt <= o_bit_cnt + 1'b1;
                        end
                    end
                end
                default: o_bit_cnt <= '0;           // wait / start
            endcase
        end
    end

    a_cnt_range: assert property (@(posedge aclk) disable iff (!aresetn)
        o_bit_cnt <= i2c_logger_pkg::ACK_BIT);

endmodule

// ==== rtl/byte_capture.sv ====
// i2c byte capture, shifts in data bits, samples ack and emits one record per byte
`timescale 1ns/1ns

module byte_capture (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                i_sda,
    input  logic                                i_scl_rise,
    input  logic                                i_start,
    input  logic [i2c_logger_pkg::CNT_W-1:0]    i_bit_cnt,
    output i2c_logger_pkg::rec_t                o_rec,
    output logic                                o_rec_valid
);

    i2c_logger_pkg::byte_t shift_q;
    logic                  first_q;
    logic                  data_rise;
    logic                  ack_rise;

    // bits 1..8 of a frame; count 9 means the first bit of a back-to-back byte
    assign data_rise = i_scl_rise &&
                       ((i_bit_cnt < i2c_logger_pkg::ACK_BIT - 1'b1) ||
                        (i_bit_cnt == i2c_logger_pkg::ACK_BIT));
    assign ack_rise  = i_scl_rise && (i_bit_cnt == i2c_logger_pkg::ACK_BIT - 1'b1);

    // ------------------------------------------------------------
    // data path
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (data_rise) begin
            shift_q <= {shift_q[i2c_logger_pkg::BYTE_W-2:0], i_sda};  // msb first
        end
        if (ack_rise) begin
            o_rec <= '{data: shift_q, ack: ~i_sda, first: first_q};
        end
    end

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_rec_valid <= 1'b0;
            first_q     <= 1'b0;
        end else begin
            o_rec_valid <= ack_rise;
            if (i_start) begin
                first_q <= 1'b1;                    // next byte is the address
            end else if (o_rec_valid) begin
                first_q <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/hold_reg.sv ====
// single-entry valid/ready holding register for any payload type
`timescale 1ns/1ns

module hold_reg #(
    parameter type T = logic [7:0]
) (
    input  logic aclk,
    input  logic aresetn,
    input  T     i_data,
    input  logic i_valid,
    input  logic i_ready,
    output T     o_data,
    output logic o_valid,
    output logic o_ready
);

    assign o_ready = !o_valid || i_ready;           // empty, or draining this clock

    always_ff @(posedge aclk) begin
        if (i_valid && o_ready) begin
            o_data <= i_data;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    a_hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

// ==== rtl/record_formatter.sv ====
// record formatter, filters records and emits optional status byte then data byte
`timescale 1ns/1ns

module record_formatter (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  i2c_logger_pkg::rec_t    i_rec,
    input  logic                    i_rec_valid,
    input  logic                    i_byte_ready,
    input  logic                    i_tx_status,
    input  logic                    i_tx_filter,
    output logic                    o_rec_ready,
    output i2c_logger_pkg::byte_t   o_byte,
    output logic                    o_byte_valid
);

    i2c_logger_pkg::rec_t  rec_q;
    i2c_logger_pkg::byte_t stat_byte;
    logic                  busy;
    logic                  stat_pend;               // status byte still to send
    logic                  xfer;
    logic                  done;

    always_comb begin
        stat_byte = '0;
        stat_byte[i2c_logger_pkg::STAT_ACK_POS]   = rec_q.ack;
        stat_byte[i2c_logger_pkg::STAT_FIRST_POS] = rec_q.first;
    end

    assign o_byte_valid = busy;
    assign o_byte       = stat_pend ? stat_byte : rec_q.data;
    assign xfer         = busy && i_byte_ready;
    assign done         = xfer && !stat_pend;       // data byte leaves
    assign o_rec_ready  = !busy || done;

    always_ff @(posedge aclk) begin
        if (i_rec_valid && o_rec_ready) begin
            rec_q <= i_rec;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy      <= 1'b0;
            stat_pend <= 1'b0;
        end else if (i_rec_valid && o_rec_ready) begin
            busy      <= !(i_tx_filter && !i_rec.ack);  // nacked bytes dropped here
            stat_pend <= i_tx_status;
        end else if (done) begin
            busy <= 1'b0;
        end else if (xfer) begin
            stat_pend <= 1'b0;
        end
    end

endmodule

// ==== rtl/i2c_logger_top.sv ====
// passive i2c bus logger top level, pins in, status/data byte stream out
`timescale 1ns/1ns

module i2c_logger_top (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    i_scl,
    input  logic                    i_sda,
    input  logic                    i_tx_status,
    input  logic                    i_tx_filter,
    input  logic                    i_tx_ready,
    output i2c_logger_pkg::byte_t   o_tx_data,
    output logic                    o_tx_valid,
    output logic                    o_bus_active,
    output logic                    o_bus_err
);

    logic                               sda_f;
    logic                               start;
    logic                               stop;
    logic                               scl_rise;
    logic                               scl_fall;
    i2c_logger_pkg::bus_state_t         state;
    logic [i2c_logger_pkg::CNT_W-1:0]   bit_cnt;
    i2c_logger_pkg::rec_t               rec;
    logic                               rec_valid;
    i2c_logger_pkg::rec_t               hr_rec;
    logic                               hr_rec_valid;
    logic                               fmt_rec_ready;
    i2c_logger_pkg::byte_t              fmt_byte;
    logic                               fmt_byte_valid;
    logic                               out_ready;

    // ------------------------------------------------------------
    // bus observer
    // ------------------------------------------------------------
    line_filter line_filter_i (
        .aclk(aclk), .aresetn(aresetn),
        .i_scl(i_scl), .i_sda(i_sda),
        .o_scl(), .o_sda(sda_f),
        .o_start(start), .o_stop(stop),
        .o_scl_rise(scl_rise), .o_scl_fall(scl_fall)
    );

    bus_fsm bus_fsm_i (
        .aclk(aclk), .aresetn(aresetn),
        .i_start(start), .i_stop(stop), .i_scl_fall(scl_fall),
        .i_bit_cnt(bit_cnt),
        .o_state(state), .o_bus_active(o_bus_active), .o_bus_err(o_bus_err)
    );

    bit_counter bit_counter_i (
        .aclk(aclk), .aresetn(aresetn),
        .i_scl_rise(scl_rise), .i_start(start), .i_stop(stop),
        .i_state(state), .o_bit_cnt(bit_cnt)
    );

    byte_capture byte_capture_i (
        .aclk(aclk), .aresetn(aresetn),
        .i_sda(sda_f), .i_scl_rise(scl_rise), .i_start(start),
        .i_bit_cnt(bit_cnt),
        .o_rec(rec), .o_rec_valid(rec_valid)
    );

    // ------------------------------------------------------------
    // record stream, no back-pressure into capture
    // ------------------------------------------------------------
    hold_reg #(.T(i2c_logger_pkg::rec_t)) rec_hold_i (
        .aclk(aclk), .aresetn(aresetn),
        .i_data(rec), .i_valid(rec_valid), .i_ready(fmt_rec_ready),
        .o_data(hr_rec), .o_valid(hr_rec_valid), .o_ready()
    );

    record_formatter record_formatter_i (
        .aclk(aclk), .aresetn(aresetn),
        .i_rec(hr_rec), .i_rec_valid(hr_rec_valid),
        .i_byte_ready(out_ready),
        .i_tx_status(i_tx_status), .i_tx_filter(i_tx_filter),
        .o_rec_ready(fmt_rec_ready),
        .o_byte(fmt_byte), .o_byte_valid(fmt_byte_valid)
    );

    hold_reg #(.T(i2c_logger_pkg::byte_t)) byte_hold_i (
        .aclk(aclk), .aresetn(aresetn),
        .i_data(fmt_byte), .i_valid(fmt_byte_valid), .i_ready(i_tx_ready),
        .o_data(o_tx_data), .o_valid(o_tx_valid), .o_ready(out_ready)
    );

endmodule

// ==== verification/tb_i2c_logger.sv ====
// directed testbench for the passive i2c bus logger
`timescale 1ns/1ns

module tb_i2c_logger;

    localparam int CLK_NS     = 40;
    localparam int HALF_CLKS  = 8;                      // scl half period in clocks
    localparam int BYTE_CLKS  = 9 * 2 * HALF_CLKS;
    localparam int FRAME_CLKS = 6 * HALF_CLKS + 200;    // start, stop and drain
    localparam int N_BYTES    = 24;
    localparam int N_FRAMES   = 8;
    localparam longint WATCHDOG_NS =
        2 * (N_BYTES * BYTE_CLKS + N_FRAMES * FRAME_CLKS + 20) * CLK_NS;

    logic                  aclk = 1'b0;
    logic                  aresetn;
    logic                  scl;
    logic                  sda;
    logic                  tx_status;
    logic                  tx_filter;
    logic                  tx_ready;
    i2c_logger_pkg::byte_t tx_data;
    logic                  tx_valid;
    logic                  bus_active;
    logic                  bus_err;

    int                    errors;
    int                    checks;
    int                    rx_count;                    // bytes taken off the stream
    logic [31:0]           lfsr;
    logic                  first_pending;               // next byte follows a start
    i2c_logger_pkg::byte_t exp_q [$];

    i2c_logger_top i2c_logger_top_i (
        .aclk(aclk), .aresetn(aresetn),
        .i_scl(scl), .i_sda(sda),
        .i_tx_status(tx_status), .i_tx_filter(tx_filter), .i_tx_ready(tx_ready),
        .o_tx_data(tx_data), .o_tx_valid(tx_valid),
        .o_bus_active(bus_active), .o_bus_err(bus_err)
    );

    initial begin
        forever #(CLK_NS / 2) aclk = ~aclk;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);                     // one step per bit
        end
        return v;
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic clocks(input int n);
        repeat (n) @(negedge aclk);
    endtask

    // output monitor, values taken before this edge's updates
    always @(posedge aclk) begin
        if (aresetn && tx_valid && tx_ready) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("output byte %0h arrived at %0t ns with no byte expected",
                         tx_data, $time);
            end else begin
                compare(32'(tx_data), 32'(exp_q.pop_front()), "output byte");
            end
        end
    end

    // ------------------------------------------------------------
    // bus driver
    // ------------------------------------------------------------
    task automatic bus_start();
        sda = 1'b1;
        scl = 1'b1;
        clocks(HALF_CLKS);
        sda = 1'b0;                                     // sda falls under scl high
        clocks(HALF_CLKS);
        scl = 1'b0;
        clocks(HALF_CLKS / 2);
        first_pending = 1'b1;
    endtask

    task automatic bus_stop();
        sda = 1'b0;
        clocks(HALF_CLKS / 2);
        scl = 1'b1;
        clocks(HALF_CLKS);
        sda = 1'b1;                                     // sda rises under scl high
        clocks(HALF_CLKS);
    endtask

    task automatic write_bit(input logic b, input logic glitch);
        sda = b;
        clocks(1);
        if (glitch) begin
            scl = 1'b1;                                 // one-clock spike on scl
            clocks(1);
            scl = 1'b0;
            clocks(HALF_CLKS / 2 - 2);
        end else begin
            clocks(HALF_CLKS / 2 - 1);
        end
        scl = 1'b1;
        clocks(HALF_CLKS / 2);
        if (glitch) begin
            sda = ~b;                                   // spike on sda, scl high
            clocks(1);
            sda = b;
            clocks(HALF_CLKS / 2 - 1);
        end else begin
            clocks(HALF_CLKS / 2);
        end
        scl = 1'b0;
        clocks(HALF_CLKS / 2);
    endtask

    task automatic write_byte(input i2c_logger_pkg::byte_t data, input logic acked,
                              input logic glitch);
        i2c_logger_pkg::byte_t stat;
        stat = '0;
        if (!(tx_filter && !acked)) begin
            if (tx_status) begin
                stat[i2c_logger_pkg::STAT_ACK_POS]   = acked;
                stat[i2c_logger_pkg::STAT_FIRST_POS] = first_pending;
                exp_q.push_back(stat);
            end
            exp_q.push_back(data);
        end
        first_pending = 1'b0;
        for (int i = i2c_logger_pkg::BYTE_W - 1; i >= 0; i--) begin
            write_bit(data[i], glitch);                 // msb first
        end
        write_bit(~acked, glitch);                      // ack is sda low
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 4 * BYTE_CLKS) begin
            clocks(1);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected output bytes never arrived by %0t ns",
                     exp_q.size(), $time);
            exp_q.delete();
        end
        clocks(2 * HALF_CLKS);                          // room for a stray byte
    endtask

    // holds ready low for len clocks once a byte waits at the output
    task automatic stall_output(input int len);
        int n;
        n = 0;
        while (!tx_valid && n < 2 * BYTE_CLKS) begin
            clocks(1);
            n++;
        end
        tx_ready = 1'b0;
        clocks(len);
        tx_ready = 1'b1;
    endtask

    // address byte acked, then n_data random bytes with the given acks
    task automatic send_frame(input int n_data, input logic [3:0] acks,
                              input logic glitch);
        bus_start();
        compare(32'(bus_active), 32'd1, "bus active after start");
        write_byte(8'(rand_bits(8)), 1'b1, glitch);
        for (int i = 0; i < n_data; i++) begin
            write_byte(8'(rand_bits(8)), acks[i], glitch);
        end
        bus_stop();
        compare(32'(bus_active), 32'd0, "bus idle after stop");
        drain();
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_plain();
        int base;
        base      = rx_count;
        tx_status = 1'b0;
        tx_filter = 1'b0;
        send_frame(3, 4'b0101, 1'b0);
        compare(32'(rx_count - base), 32'd4, "bytes in plain frame");
    endtask

    task automatic test_status();
        int base;
        base      = rx_count;
        tx_status = 1'b1;
        tx_filter = 1'b0;
        send_frame(3, 4'b0110, 1'b0);
        compare(32'(rx_count - base), 32'd8, "bytes with status on");
    endtask

    task automatic test_filter();
        int base;
        base      = rx_count;
        tx_status = 1'b0;
        tx_filter = 1'b1;
        send_frame(3, 4'b0010, 1'b0);
        compare(32'(rx_count - base), 32'd2, "bytes with filter on");
        tx_filter = 1'b0;
    endtask

    task automatic test_protocol_error();
        int base;
        base = rx_count;
        bus_start();
        for (int i = 0; i < 4; i++) begin
            write_bit(1'(rand_bits(1)), 1'b0);
        end
        bus_stop();                                     // cuts the byte short
        drain();
        compare(32'(bus_err), 32'd1, "error flag after short byte");
        compare(32'(rx_count - base), 32'd0, "bytes from short byte");
        bus_start();
        compare(32'(bus_err), 32'd0, "error flag after next start");
        write_byte(8'(rand_bits(8)), 1'b1, 1'b0);
        bus_stop();
        drain();
        compare(32'(rx_count - base), 32'd1, "bytes after recovery");
    endtask

    task automatic test_glitches();
        int base;
        base = rx_count;
        scl  = 1'b0;                                    // idle spikes
        clocks(1);
        scl  = 1'b1;
        clocks(3);
        sda  = 1'b0;
        clocks(1);
        sda  = 1'b1;
        clocks(3 * HALF_CLKS);
        compare(32'(bus_err), 32'd0, "error flag after idle spikes");
        send_frame(1, 4'b0001, 1'b1);
        compare(32'(bus_err), 32'd0, "error flag after spikes");
        compare(32'(rx_count - base), 32'd2, "bytes from spiked frame");
    endtask

    task automatic test_backpressure();
        int base;
        int gap [3];
        int len [3];
        base      = rx_count;
        tx_status = 1'b1;
        for (int i = 0; i < 3; i++) begin
            gap[i] = 10 + int'(rand_bits(5));
            len[i] = 30 + int'(rand_bits(6));           // under one byte time
        end
        fork
            send_frame(3, 4'b0011, 1'b0);
            for (int i = 0; i < 3; i++) begin
                clocks(gap[i]);
                stall_output(len[i]);
            end
        join
        compare(32'(rx_count - base), 32'd8, "bytes under back-pressure");
    endtask

    // ------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------
    initial begin
        errors        = 0;
        checks        = 0;
        rx_count      = 0;
        lfsr          = 32'h5a8c_bef4;
        first_pending = 1'b0;
        aresetn       = 1'b0;
        scl           = 1'b1;
        sda           = 1'b1;
        tx_status     = 1'b0;
        tx_filter     = 1'b0;
        tx_ready      = 1'b1;
        clocks(5);
        aresetn = 1'b1;
        clocks(5);
        compare(32'(tx_valid), 32'd0, "valid after reset");
        compare(32'(bus_active), 32'd0, "bus active after reset");
        compare(32'(bus_err), 32'd0, "error flag after reset");
        test_plain();
        test_status();
        test_filter();
        test_protocol_error();
        test_glitches();
        test_backpressure();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/i2c_logger_pkg.sv
rtl/line_filter.sv
rtl/bus_fsm.sv
rtl/bit_counter.sv
rtl/byte_capture.sv
rtl/hold_reg.sv
rtl/record_formatter.sv
rtl/i2c_logger_top.sv
verification/tb_i2c_logger.sv

// ==== Makefile ====
TOP = tb_i2c_logger

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
